// File: all.f
source/memPkg.sv
source/cachePkg.sv
source/tagStore.sv
source/dataStore.sv
source/mainMemory.sv
source/cacheCtrl.sv
source/dataL1.sv
tests/dataL1_asserts.sv
tests/tbDataL1.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tbDataL1
FILELIST  = all.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+1000
PASSTEXT  = TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tests/tbDataL1.sv
// L1 data cache testbench
`timescale 1ns/10ps

module tbDataL1;

    import memPkg::*;
    import cachePkg::*;

    localparam int unsigned seed = 32'h905c;
    localparam int resetCycles = 8;
    // Dirty miss is the longest request at 19 cycles
    localparam int doneTimeout = 40;
    localparam int randomRequests = 60;

    logic clk;
    logic rstN;
    logic read;
    logic write;
    addrT address;
    wordT writeValue;
    wordT readValue;
    logic hit;
    logic busy;
    logic done;

    int requestCount;
    int timeoutCount;
    int assertErrors;

    dataL1 u_dut (
        .clk, .rstN, .read, .write, .address, .writeValue,
        .readValue, .hit, .busy, .done
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic addrT makeAddr(input tagT tag, input indexT index, input offsetT offset);
        return {tag, index, offset};
    endfunction

    // Issue one request on a falling edge and wait for its done
    task automatic runRequest(input logic doRead, input logic doWrite,
                              input addrT addr, input wordT data);
        int waited;
        requestCount++;
        read       = doRead;
        write      = doWrite;
        address    = addr;
        writeValue = data;
        @(negedge clk);
        waited = 1;
        while (!done && waited < doneTimeout) begin
            // Junk while busy must be ignored
            read       = 1'($urandom);
            write      = 1'($urandom);
            address    = addrT'($urandom);
            writeValue = wordT'($urandom);
            @(negedge clk);
            waited++;
        end
        // Idle before the closing edge so nothing extra is accepted
        read  = 1'b0;
        write = 1'b0;
        if (!done) begin
            timeoutCount++;
            $display("Request %0d to address %h never finished", requestCount, addr);
        end
    endtask

    initial begin
        indexT  idx;
        offsetT off;
        addrT   addr;
        void'($urandom(seed));
        rstN         = 1'b0;
        read         = 1'b0;
        write        = 1'b0;
        address      = '0;
        writeValue   = '0;
        requestCount = 0;
        timeoutCount = 0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        // First touch of the index allocates on write
        idx = indexT'($urandom);
        off = offsetT'($urandom);
        runRequest(1'b0, 1'b1, makeAddr(2'd0, idx, off), wordT'($urandom));
        runRequest(1'b1, 1'b0, makeAddr(2'd0, idx, off), '0);

        // More words of the same line hit
        for (int i = 0; i < wordsPerLine; i += 2) begin
            runRequest(1'b0, 1'b1, makeAddr(2'd0, idx, offsetT'(i)), wordT'($urandom));
        end

        // Tag 1 on the same index evicts the dirty tag 0 line
        runRequest(1'b0, 1'b1, makeAddr(2'd1, idx, offsetT'($urandom)), wordT'($urandom));

        // Tag 0 comes back from memory
        for (int i = 0; i < wordsPerLine; i++) begin
            runRequest(1'b1, 1'b0, makeAddr(2'd0, idx, offsetT'(i)), '0);
        end

        // Read and write together
        runRequest(1'b1, 1'b1, makeAddr(2'd2, idx, off), wordT'($urandom));
        runRequest(1'b1, 1'b0, makeAddr(2'd2, idx, off), '0);

        // Mixed traffic over a handful of indices and all tags
        for (int i = 0; i < randomRequests; i++) begin
            addr = makeAddr(tagT'($urandom), idx + indexT'($urandom % 4), offsetT'($urandom));
            if ($urandom % 2 == 0) begin
                runRequest(1'b0, 1'b1, addr, wordT'($urandom));
            end else begin
                runRequest(1'b1, 1'b0, addr, '0);
            end
        end

        // Let the last checks fire before the count is read
        repeat (2) @(posedge clk);
        assertErrors = u_dut.u_asserts.errCount;
        $display("Assertion errors %0d, request timeouts %0d", assertErrors, timeoutCount);
        if (assertErrors == 0 && timeoutCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/dataL1_asserts.sv
// Cache shadow model and checks
`timescale 1ns/10ps

module dataL1Asserts (
    input logic          clk,
    input logic          rstN,
    input logic          read,
    input logic          write,
    input memPkg::addrT  address,
    input memPkg::wordT  writeValue,
    input memPkg::wordT  readValue,
    input logic          hit,
    input logic          busy,
    input logic          done
);

    import memPkg::*;
    import cachePkg::*;

    // Cycles from acceptance to done
    // Miss is lookup, 9 refill cycles and respond
    // A dirty miss adds 8 writeback cycles
    localparam int hitLatency       = 1;
    localparam int cleanMissLatency = wordsPerLine + 3;
    localparam int dirtyMissLatency = 2 * wordsPerLine + 3;

    // Every word ever written and its written flag
    wordT                shMem [memWords];
    logic [memWords-1:0] shWritten;

    // Line state per index
    tagT                 shTag [numLines];
    logic [numLines-1:0] shValid;
    logic [numLines-1:0] shDirty;

    // Incoming request fields
    tagT   inTag;
    indexT inIndex;
    logic  accept;
    logic  hitNow;

    // Outstanding request
    logic pending;
    logic expHit;
    logic expRead;
    logic expKnown;
    wordT expValue;
    int   expLatency;
    int   cycles;

    int errCount = 0;

    assign inTag   = address[addrWidth-1 -: tagWidth];
    assign inIndex = address[offsetWidth +: indexWidth];
    // Write or read while idle
    // Write wins when both are high
    assign accept  = (read || write) && !busy;
    assign hitNow  = shValid[inIndex] && (shTag[inIndex] == inTag);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shValid    <= '0;
            shDirty    <= '0;
            shWritten  <= '0;
            pending    <= 1'b0;
            expHit     <= 1'b0;
            expRead    <= 1'b0;
            expKnown   <= 1'b0;
            expValue   <= '0;
            expLatency <= 0;
            cycles     <= 0;
        end else if (accept) begin
            expHit   <= hitNow;
            expRead  <= !write;
            expKnown <= !write && shWritten[address];
            expValue <= shMem[address];
            if (hitNow) begin
                expLatency <= hitLatency;
            end else if (shValid[inIndex] && shDirty[inIndex]) begin
                expLatency <= dirtyMissLatency;
            end else begin
                expLatency <= cleanMissLatency;
            end
            // Refill leaves the line clean and a write dirties it
            shValid[inIndex] <= 1'b1;
            shDirty[inIndex] <= write || (hitNow && shDirty[inIndex]);
            if (write) begin
                shWritten[address] <= 1'b1;
            end
            pending <= 1'b1;
            cycles  <= 1;
        end else if (done) begin
            pending <= 1'b0;
        end else if (pending) begin
            cycles <= cycles + 1;
        end
    end

    // Shadow data and tags
    always_ff @(posedge clk) begin
        if (rstN && accept) begin
            shTag[inIndex] <= inTag;
            if (write) begin
                shMem[address] <= writeValue;
            end
        end
    end

    // Outputs change on the rising edge and are checked on the falling edge
    resetQuiet: assert property (@(negedge clk)
        !rstN |-> (!busy && !done && !hit && readValue == '0))
        else begin
            errCount++;
            $error("error %0t: outputs not idle during reset", $time);
        end

    hitMatch: assert property (@(negedge clk) disable iff (!rstN)
        done |-> (hit == expHit))
        else begin
            errCount++;
            $error("error %0t: hit %b, expected %b", $time, hit, expHit);
        end

    readMatch: assert property (@(negedge clk) disable iff (!rstN)
        (done && expKnown) |-> (readValue == expValue))
        else begin
            errCount++;
            $error("error %0t: read %h, expected %h", $time, readValue, expValue);
        end

    // Value stays put until the next read finishes
    readHolds: assert property (@(negedge clk) disable iff (!rstN)
        !(done && expRead) |-> $stable(readValue))
        else begin
            errCount++;
            $error("error %0t: readValue changed outside a read", $time);
        end

    busyRule: assert property (@(negedge clk) disable iff (!rstN)
        busy == (pending && !done))
        else begin
            errCount++;
            $error("error %0t: busy %b with pending %b, done %b", $time, busy, pending, done);
        end

    // One done per request at the expected cycle
    doneTiming: assert property (@(negedge clk) disable iff (!rstN)
        done |-> (pending && cycles == expLatency))
        else begin
            errCount++;
            $error("error %0t: done after %0d cycles, expected %0d", $time, cycles, expLatency);
        end

endmodule

bind dataL1 dataL1Asserts u_asserts (
    .clk        (clk),
    .rstN       (rstN),
    .read       (read),
    .write      (write),
    .address    (address),
    .writeValue (writeValue),
    .readValue  (readValue),
    .hit        (hit),
    .busy       (busy),
    .done       (done)
);

// File: source/dataL1.sv
// L1 data cache top
`timescale 1ns/10ps

module dataL1 (
    input  logic          clk,
    input  logic          rstN,
    input  logic          read,
    input  logic          write,
    input  memPkg::addrT  address,
    input  memPkg::wordT  writeValue,
    output memPkg::wordT  readValue,
    output logic          hit,
    output logic          busy,
    output logic          done
);

    import memPkg::*;
    import cachePkg::*;

    // Tag store
    indexT lookupIndex;
    tagT   lookupTag;
    tagT   victimTag;
    logic  lineHit;
    logic  lineDirty;
    logic  tagFill;
    logic  tagMarkDirty;

    // Data store
    offsetT wordOffset;
    offsetT beatSel;
    offsetT fillBeat;
    logic   wordWrite;
    logic   fillWrite;
    wordT   wordIn;
    wordT   fillWord;
    wordT   wordOut;
    wordT   beatOut;

    // Main memory
    addrT memAddr;
    logic memWrite;
    wordT memWriteData;
    wordT memReadData;

    cacheCtrl u_ctrl (
        .clk, .rstN, .read, .write, .address, .writeValue,
        .lineHit, .lineDirty, .victimTag,
        .wordOut, .beatOut, .memReadData,
        .lookupIndex, .lookupTag,
        .wordOffset, .beatSel, .fillBeat,
        .wordWrite, .fillWrite, .tagFill, .tagMarkDirty, .memWrite,
        .wordIn, .fillWord, .memWriteData, .memAddr,
        .readValue, .hit, .busy, .done
    );

    tagStore u_tags (
        .clk, .rstN, .lookupIndex, .lookupTag,
        .tagFill, .tagMarkDirty,
        .lineHit, .lineDirty, .victimTag
    );

    // Same line index as the tag lookup
    dataStore u_data (
        .clk,
        .lineIndex (lookupIndex),
        .wordOffset, .fillBeat, .beatSel,
        .wordWrite, .fillWrite, .wordIn, .fillWord,
        .wordOut, .beatOut
    );

    mainMemory u_mem (
        .clk, .memAddr, .memWrite, .memWriteData, .memReadData
    );

endmodule

// File: source/cacheCtrl.sv
// Cache request controller
`timescale 1ns/10ps

module cacheCtrl (
    input  logic              clk,
    input  logic              rstN,
    input  logic              read,
    input  logic              write,
    input  memPkg::addrT      address,
    input  memPkg::wordT      writeValue,
    input  logic              lineHit,
    input  logic              lineDirty,
    input  cachePkg::tagT     victimTag,
    input  memPkg::wordT      wordOut,
    input  memPkg::wordT      beatOut,
    input  memPkg::wordT      memReadData,
    output cachePkg::indexT   lookupIndex,
    output cachePkg::tagT     lookupTag,
    output cachePkg::offsetT  wordOffset,
    output cachePkg::offsetT  beatSel,
    output cachePkg::offsetT  fillBeat,
    output logic              wordWrite,
    output logic              fillWrite,
    output logic              tagFill,
    output logic              tagMarkDirty,
    output logic              memWrite,
    output memPkg::wordT      wordIn,
    output memPkg::wordT      fillWord,
    output memPkg::wordT      memWriteData,
    output memPkg::addrT      memAddr,
    output memPkg::wordT      readValue,
    output logic              hit,
    output logic              busy,
    output logic              done
);

    import memPkg::*;
    import cachePkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stWriteback,
        stRefill,
        stRespond
    } stateT;

    // One extra bit so refill can count its ninth cycle
    typedef logic [offsetWidth:0] beatCntT;

    localparam beatCntT lastWbBeat   = beatCntT'(wordsPerLine - 1);
    localparam beatCntT lastFillBeat = beatCntT'(wordsPerLine);

    stateT   state;
    beatCntT beatCnt;
    offsetT  beatLow;

    // Captured request
    tagT    reqTag;
    indexT  reqIndex;
    offsetT reqOffset;
    logic   reqWrite;
    wordT   reqData;

    // Last read result
    wordT readHold;

    logic accept;
    logic readDone;

    // Hits finish in lookup, misses finish in respond
    assign done     = ((state == stLookup) && lineHit) || (state == stRespond);
    assign hit      = (state == stLookup) && lineHit;
    // Busy drops on the done cycle so the next request lands on its closing edge
    assign busy     = (state != stIdle) && !done;
    assign accept   = (read || write) && !busy;
    assign readDone = done && !reqWrite;

    // Lookup and word access always use the captured request
    assign lookupIndex = reqIndex;
    assign lookupTag   = reqTag;
    assign wordOffset  = reqOffset;

    // Word op on the done cycle
    assign wordWrite    = done && reqWrite;
    assign tagMarkDirty = done && reqWrite;
    assign wordIn       = reqData;

    // Read result bypasses the hold register on its own done cycle
    assign readValue = readDone ? wordOut : readHold;

    assign beatLow = beatCnt[offsetWidth-1:0];
    assign beatSel = beatLow;

    // Writeback drives one beat per cycle to memory
    assign memWrite     = (state == stWriteback);
    assign memWriteData = beatOut;

    // Victim tag while writing back, request tag while refilling
    assign memAddr = {(state == stWriteback) ? victimTag : reqTag, reqIndex, beatLow};

    // Refill pipeline, beat k-1 lands while address k goes out
    assign fillWrite = (state == stRefill) && (beatCnt != '0);
    assign fillBeat  = offsetT'(beatCnt - 1'b1);
    assign fillWord  = memReadData;

    // Tag goes in with the last beat
    assign tagFill = (state == stRefill) && (beatCnt == lastFillBeat);

    // Request capture, write wins over read
    always_ff @(posedge clk) begin
        if (accept) begin
            reqTag    <= address[addrWidth-1 -: tagWidth];
            reqIndex  <= address[offsetWidth +: indexWidth];
            reqOffset <= address[offsetWidth-1:0];
            reqWrite  <= write;
            reqData   <= writeValue;
        end
    end

    // Sequence and read hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            beatCnt  <= '0;
            readHold <= '0;
        end else begin
            if (readDone) begin
                readHold <= wordOut;
            end
            case (state)
                stIdle, stRespond: begin
                    state <= accept ? stLookup : stIdle;
                end
                stLookup: begin
                    beatCnt <= '0;
                    if (lineHit) begin
                        // Back to back hits stay in lookup
                        state <= accept ? stLookup : stIdle;
                    end else if (lineDirty) begin
                        state <= stWriteback;
                    end else begin
                        state <= stRefill;
                    end
                end
                stWriteback: begin
                    if (beatCnt == lastWbBeat) begin
                        beatCnt <= '0;
                        state   <= stRefill;
                    end else begin
                        beatCnt <= beatCnt + 1'b1;
                    end
                end
                stRefill: begin
                    // 9 cycles, the last one only writes beat 7
                    if (beatCnt == lastFillBeat) begin
                        state <= stRespond;
                    end else begin
                        beatCnt <= beatCnt + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: source/mainMemory.sv
// Backing main memory
`timescale 1ns/10ps

module mainMemory (
    input  logic          clk,
    input  memPkg::addrT  memAddr,
    input  logic          memWrite,
    input  memPkg::wordT  memWriteData,
    output memPkg::wordT  memReadData
);

    import memPkg::*;

    // 64K words
    wordT mem [memWords];

    // Write and read share one address
    // Read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr] <= memWriteData;
        end
        memReadData <= mem[memAddr];
    end

endmodule

// File: source/dataStore.sv
// Cache line data store
`timescale 1ns/10ps

module dataStore (
    input  logic              clk,
    input  cachePkg::indexT   lineIndex,
    input  cachePkg::offsetT  wordOffset,
    input  cachePkg::offsetT  fillBeat,
    input  cachePkg::offsetT  beatSel,
    input  logic              wordWrite,
    input  logic              fillWrite,
    input  memPkg::wordT      wordIn,
    input  memPkg::wordT      fillWord,
    output memPkg::wordT      wordOut,
    output memPkg::wordT      beatOut
);

    import memPkg::*;
    import cachePkg::*;

    // 2048 lines of 8 words
    lineT lines [numLines];

    // Request word, read by offset
    assign wordOut = lines[lineIndex][wordOffset];

    // Writeback beat, read by beat number
    assign beatOut = lines[lineIndex][beatSel];

    // One word written per cycle
    // Request writes and refill beats never overlap
    always_ff @(posedge clk) begin
        if (wordWrite) begin
            lines[lineIndex][wordOffset] <= wordIn;
        end else if (fillWrite) begin
            lines[lineIndex][fillBeat] <= fillWord;
        end
    end

endmodule

// File: source/tagStore.sv
// Cache tag, valid and dirty store
`timescale 1ns/10ps

module tagStore (
    input  logic             clk,
    input  logic             rstN,
    input  cachePkg::indexT  lookupIndex,
    input  cachePkg::tagT    lookupTag,
    input  logic             tagFill,
    input  logic             tagMarkDirty,
    output logic             lineHit,
    output logic             lineDirty,
    output cachePkg::tagT    victimTag
);

    import cachePkg::*;

    // One tag per line
    tagT tags [numLines];

    // Status bits, one per line
    logic [numLines-1:0] valid;
    logic [numLines-1:0] dirty;

    // Lookup straight off the stored arrays
    assign victimTag = tags[lookupIndex];
    assign lineHit   = valid[lookupIndex] && (tags[lookupIndex] == lookupTag);

    // Dirty only counts on a valid line
    assign lineDirty = valid[lookupIndex] && dirty[lookupIndex];

    // Status bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (tagFill) begin
                // Freshly refilled line matches memory
                valid[lookupIndex] <= 1'b1;
                dirty[lookupIndex] <= 1'b0;
            end else if (tagMarkDirty) begin
                dirty[lookupIndex] <= 1'b1;
            end
        end
    end

    // Tag install on refill
    always_ff @(posedge clk) begin
        if (tagFill) begin
            tags[lookupIndex] <= lookupTag;
        end
    end

endmodule

// File: source/cachePkg.sv
// L1 data cache geometry

package cachePkg;

    // Address split is tag, block index, word offset (MSB to LSB)
    localparam int tagWidth    = 2;
    localparam int indexWidth  = 11;
    localparam int offsetWidth = 3;

    // 2048 lines
    localparam int numLines = 1 << indexWidth;

    // 8 words per line
    localparam int wordsPerLine = 1 << offsetWidth;

    // Address fields
    typedef logic [tagWidth-1:0]    tagT;
    typedef logic [indexWidth-1:0]  indexT;
    typedef logic [offsetWidth-1:0] offsetT;

    // One line, word 0 in the low bits, 128 bits in all
    typedef memPkg::wordT [wordsPerLine-1:0] lineT;

endpackage

// File: source/memPkg.sv
// Main memory word and address types

package memPkg;

    // Data word
    localparam int wordWidth = 16;

    // Word address, one full 64K space
    localparam int addrWidth = 16;
    localparam int memWords  = 1 << addrWidth;

    // One data word
    typedef logic [wordWidth-1:0] wordT;

    // One word address
    typedef logic [addrWidth-1:0] addrT;

endpackage
